// ==== hdl/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // architectural register space, x0 reads as zero
    localparam int ARCH_REGS = 32;

    typedef logic [4:0] arch_reg_t;

    // prn 0 is the permanent home of x0
    typedef logic [5:0] prn_t;

    // one slot of a rename group, slot 0 is oldest
    typedef struct packed {
        logic      valid;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
    } rename_req_t;

    // old_prn goes to the reorder buffer, returned at commit
    typedef struct packed {
        prn_t src1_prn;
        prn_t src2_prn;
        prn_t dest_prn;
        prn_t old_prn;
    } rename_resp_t;

endpackage

`default_nettype wire

// ==== hdl/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;
    import rename_pkg::*;

    typedef logic [31:0] data_t;

    // stored value plus ready bit
    typedef struct packed {
        logic  valid;
        data_t data;
    } prf_entry_t;

    // writeback from a functional unit, prn 0 means no write
    typedef struct packed {
        data_t data;
        prn_t  prn;
    } prf_write_t;

endpackage

`default_nettype wire

// ==== hdl/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module map_table
    import rename_pkg::*;
#(
    parameter int width = 2
) (
    input  wire logic                         clock,
    input  wire logic                         reset,
    input  wire rename_req_t  [width-1:0]     rename_req,
    input  wire logic         [width-1:0]     alloc_fire,
    input  wire prn_t         [width-1:0]     alloc_prn,
    output rename_resp_t      [width-1:0]     rename_resp
);

    // speculative architectural to physical mapping
    prn_t mapping [ARCH_REGS];

    // lookups with forwarding from older slots of the same group
    always_comb begin
        for (int i = 0; i < width; i++) begin
            rename_resp[i].src1_prn = mapping[rename_req[i].src1];
            rename_resp[i].src2_prn = mapping[rename_req[i].src2];
            rename_resp[i].old_prn  = mapping[rename_req[i].dest];
            rename_resp[i].dest_prn = alloc_prn[i];

            // walk older slots in order so the youngest writer wins
            for (int j = 0; j < i; j++) begin
                if (alloc_fire[j]) begin
                    if (rename_req[j].dest == rename_req[i].src1) begin
                        rename_resp[i].src1_prn = alloc_prn[j];
                    end
                    if (rename_req[j].dest == rename_req[i].src2) begin
                        rename_resp[i].src2_prn = alloc_prn[j];
                    end
                    if (rename_req[j].dest == rename_req[i].dest) begin
                        rename_resp[i].old_prn = alloc_prn[j];
                    end
                end
            end
        end
    end

    // identity map out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < ARCH_REGS; a++) begin
                mapping[a] <= prn_t'(a);
            end
        end else begin
            // later slots overwrite earlier ones on a shared dest
            for (int i = 0; i < width; i++) begin
                if (alloc_fire[i]) begin
                    mapping[rename_req[i].dest] <= alloc_prn[i];
                end
            end
        end
    end

    // free list must never hand a register to x0
    generate
        for (genvar i = 0; i < width; i++) begin : g_fire_chk
            a_no_x0_alloc: assert property (
                @(posedge clock) disable iff (reset)
                alloc_fire[i] |-> rename_req[i].dest != '0
            ) else $error("map_table: slot %0d fired with dest x0", i);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list
    import rename_pkg::*;
#(
    parameter int width     = 2,
    parameter int phys_regs = 64
) (
    input  wire logic                     clock,
    input  wire logic                     reset,
    input  wire rename_req_t [width-1:0]  rename_req,
    input  wire prn_t        [width-1:0]  commit_prn,
    output logic                          stall,
    output logic             [width-1:0]  alloc_fire,
    output prn_t             [width-1:0]  alloc_prn
);

    // registers not pinned to the reset identity map
    localparam int cap     = phys_regs - ARCH_REGS;
    localparam int idx_w   = $clog2(cap);
    localparam int count_w = $clog2(cap + 1);

    typedef logic [idx_w-1:0]   idx_t;
    typedef logic [count_w-1:0] count_t;

    prn_t   queue [cap];
    idx_t   head;
    idx_t   tail;
    count_t count;

    logic   [width-1:0] need;
    count_t need_count;
    count_t pop_count;
    count_t push_count;
    idx_t   push_idx [width];

    // circular index, offset is always below cap
    function automatic idx_t wrap(input idx_t base, input count_t off);
        int unsigned sum;
        sum = int'(base) + int'(off);
        if (sum >= cap) begin
            sum = sum - cap;
        end
        return idx_t'(sum);
    endfunction

    always_comb begin
        count_t pos;
        count_t k;

        need_count = '0;
        for (int i = 0; i < width; i++) begin
            need[i]    = rename_req[i].valid && (rename_req[i].dest != '0);
            need_count = need_count + count_t'(need[i]);
        end

        // all or nothing, the group waits as a whole
        stall = count < need_count;

        pos = '0;
        for (int i = 0; i < width; i++) begin
            alloc_fire[i] = need[i] && !stall;
            alloc_prn[i]  = alloc_fire[i] ? queue[wrap(head, pos)] : '0;
            pos           = pos + count_t'(alloc_fire[i]);
        end
        pop_count = pos;

        // commit slots pack densely at the tail
        k = '0;
        for (int i = 0; i < width; i++) begin
            push_idx[i] = wrap(tail, k);
            k           = k + count_t'(commit_prn[i] != '0);
        end
        push_count = k;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= count_t'(cap);
            for (int k = 0; k < cap; k++) begin
                queue[k] <= prn_t'(ARCH_REGS + k);
            end
        end else begin
            for (int i = 0; i < width; i++) begin
                if (commit_prn[i] != '0) begin
                    queue[push_idx[i]] <= commit_prn[i];
                end
            end
            head  <= wrap(head, pop_count);
            tail  <= wrap(tail, push_count);
            count <= count - pop_count + push_count;
        end
    end

    // reorder buffer can only return what rename handed out
    a_count_bound: assert property (
        @(posedge clock) disable iff (reset)
        count <= count_t'(cap)
    ) else $error("free_list: count %0d above capacity", count);

    generate
        for (genvar i = 0; i < width; i++) begin : g_commit_chk
            a_commit_range: assert property (
                @(posedge clock) disable iff (reset)
                commit_prn[i] != '0 |-> int'(commit_prn[i]) < phys_regs
            ) else $error("free_list: commit prn %0d out of range", commit_prn[i]);
        end
    endgenerate

endmodule

`default_nettype wire

// ==== hdl/prf.sv ====
`timescale 1ns/1ps
`default_nettype none

module prf
    import rename_pkg::*;
    import regfile_pkg::*;
#(
    parameter int width     = 2,
    parameter int phys_regs = 64
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire prn_t        [2*width-1:0]     read_prn,
    output prf_entry_t       [2*width-1:0]     read_value,
    input  wire prf_write_t  [width-1:0]       write_data,
    input  wire prn_t        [width-1:0]       alloc_prn,
    input  wire logic        [width-1:0]       alloc_fire
);

    prf_entry_t entries [phys_regs];

    logic [width-1:0] write_valid;

    always_comb begin
        for (int j = 0; j < width; j++) begin
            write_valid[j] = write_data[j].prn != '0;
        end
    end

    // two read ports per slot, same-cycle writeback wins over storage
    always_comb begin
        for (int i = 0; i < 2 * width; i++) begin
            read_value[i] = entries[read_prn[i]];
            for (int j = 0; j < width; j++) begin
                if (write_valid[j] && write_data[j].prn == read_prn[i]) begin
                    read_value[i] = '{valid: 1'b1, data: write_data[j].data};
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // committed state of x0..x31 is zero
            for (int k = 0; k < phys_regs; k++) begin
                entries[k] <= '{valid: (k < ARCH_REGS), data: '0};
            end
        end else begin
            for (int j = 0; j < width; j++) begin
                if (write_valid[j]) begin
                    entries[write_data[j].prn] <= '{valid: 1'b1, data: write_data[j].data};
                end
            end
            // new producer pending, consumers must wait
            for (int i = 0; i < width; i++) begin
                if (alloc_fire[i]) begin
                    entries[alloc_prn[i]].valid <= 1'b0;
                end
            end
        end
    end

    // a register cannot be freshly renamed while its old producer writes back
    generate
        for (genvar i = 0; i < width; i++) begin : g_alloc_chk
            for (genvar j = 0; j < width; j++) begin : g_write_chk
                a_no_write_on_alloc: assert property (
                    @(posedge clock) disable iff (reset)
                    alloc_fire[i] |-> !(write_valid[j] && write_data[j].prn == alloc_prn[i])
                ) else $error("prf: prn %0d written and allocated together", alloc_prn[i]);
            end
        end
    endgenerate

    a_zero_reg: assert property (
        @(posedge clock) disable iff (reset)
        entries[0].valid && entries[0].data == '0
    ) else $error("prf: entry 0 lost its zero value");

endmodule

`default_nettype wire

// ==== hdl/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core
    import rename_pkg::*;
    import regfile_pkg::*;
#(
    parameter int width     = 2,
    parameter int phys_regs = 64
) (
    input  wire logic                          clock,
    input  wire logic                          reset,
    input  wire rename_req_t [width-1:0]       rename_req,
    output rename_resp_t     [width-1:0]       rename_resp,
    output logic                               stall,
    input  wire prn_t        [2*width-1:0]     read_prn,
    output prf_entry_t       [2*width-1:0]     read_value,
    input  wire prf_write_t  [width-1:0]       write_data,
    input  wire prn_t        [width-1:0]       commit_prn
);

    // per-slot allocation from the free list
    logic [width-1:0] alloc_fire;
    prn_t [width-1:0] alloc_prn;

    free_list #(
        .width      (width),
        .phys_regs  (phys_regs)
    ) free_list_i (
        .clock      (clock),
        .reset      (reset),
        .rename_req (rename_req),
        .commit_prn (commit_prn),
        .stall      (stall),
        .alloc_fire (alloc_fire),
        .alloc_prn  (alloc_prn)
    );

    map_table #(
        .width       (width)
    ) map_table_i (
        .clock       (clock),
        .reset       (reset),
        .rename_req  (rename_req),
        .alloc_fire  (alloc_fire),
        .alloc_prn   (alloc_prn),
        .rename_resp (rename_resp)
    );

    // new destinations go invalid until their writeback
    prf #(
        .width      (width),
        .phys_regs  (phys_regs)
    ) prf_i (
        .clock      (clock),
        .reset      (reset),
        .read_prn   (read_prn),
        .read_value (read_value),
        .write_data (write_data),
        .alloc_prn  (alloc_prn),
        .alloc_fire (alloc_fire)
    );

endmodule

`default_nettype wire

// ==== tb/tb_rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core
    import rename_pkg::*;
    import regfile_pkg::*;
();

    localparam int width         = 2;
    localparam int phys_regs     = 64;
    localparam int reset_cycles  = 10;
    localparam int idle_cycles   = 8;
    localparam int num_cycles    = 1500;
    localparam int timeout_limit = reset_cycles + idle_cycles + num_cycles + 482;
    // no commits in this window so the free list runs dry
    localparam int hold_start    = 400;
    localparam int hold_end      = 600;

    logic                       clock;
    logic                       reset;
    rename_req_t  [width-1:0]   rename_req;
    rename_resp_t [width-1:0]   rename_resp;
    logic                       stall;
    prn_t         [2*width-1:0] read_prn;
    prf_entry_t   [2*width-1:0] read_value;
    prf_write_t   [width-1:0]   write_data;
    prn_t         [width-1:0]   commit_prn;

    // expected outputs for the inputs now on the pins
    rename_resp_t [width-1:0]   exp_resp;
    logic                       exp_stall;
    prf_entry_t   [2*width-1:0] exp_read;

    // reference model
    prn_t        model_map [ARCH_REGS];
    prf_entry_t  model_prf [phys_regs];
    prn_t        free_q [$];
    prn_t        old_q [$];
    prn_t        unwritten_q [$];
    prn_t        last_alloc = '0;
    logic [15:0] lfsr_state = 16'd60;
    int          cycle_count = 0;

    rename_core #(
        .width     (width),
        .phys_regs (phys_regs)
    ) rename_core_i (.*);

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: test did not finish within %0d cycles", timeout_limit);
            abort_run();
        end
    end

    a_stall: assert property (@(posedge clock) disable iff (reset) stall == exp_stall)
        else begin
            $display("Mismatch stall: got %h expected %h", $sampled(stall), $sampled(exp_stall));
            abort_run();
        end

    for (genvar i = 0; i < width; i++) begin : g_resp_chk
        // responses carry no meaning under stall
        a_resp: assert property (@(posedge clock) disable iff (reset)
            !exp_stall |-> rename_resp[i] == exp_resp[i])
            else begin
                $display("Mismatch rename_resp[%0d]: got %h expected %h", i,
                    $sampled(rename_resp[i]), $sampled(exp_resp[i]));
                abort_run();
            end
    end

    for (genvar q = 0; q < 2 * width; q++) begin : g_read_chk
        a_read: assert property (@(posedge clock) disable iff (reset)
            read_value[q] == exp_read[q])
            else begin
                $display("Mismatch read_value[%0d]: got %h expected %h", q,
                    $sampled(read_value[q]), $sampled(exp_read[q]));
                abort_run();
            end
    end

    initial begin
        rename_req_t  [width-1:0]   req;
        prf_write_t   [width-1:0]   wr;
        prn_t         [width-1:0]   cm;
        prn_t         [2*width-1:0] rd;
        rename_resp_t [width-1:0]   resp;
        prf_entry_t   [2*width-1:0] rdv;
        prn_t                       walk_map [ARCH_REGS];
        prn_t                       p;
        int                         need_n;
        int                         idx;
        logic                       stall_n;

        reset = 1'b1;
        rename_req = '0;
        read_prn = '0;
        write_data = '0;
        commit_prn = '0;
        exp_resp = '0;
        exp_stall = 1'b0;
        for (int q = 0; q < 2 * width; q++) begin
            exp_read[q] = '{valid: 1'b1, data: '0};
        end
        for (int a = 0; a < ARCH_REGS; a++) begin
            model_map[a] = prn_t'(a);
        end
        for (int q = 0; q < phys_regs; q++) begin
            model_prf[q] = '{valid: (q < ARCH_REGS), data: '0};
            if (q >= ARCH_REGS) begin
                free_q.push_back(prn_t'(q));
            end
        end
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;

        for (int c = 0; c < idle_cycles + num_cycles; c++) begin
            @(posedge clock);
            // the DUT took the previous inputs at this edge
            for (int j = 0; j < width; j++) begin
                if (write_data[j].prn != '0) begin
                    model_prf[write_data[j].prn] = '{valid: 1'b1, data: write_data[j].data};
                end
            end
            for (int i = 0; i < width; i++) begin
                if (!exp_stall && rename_req[i].valid && rename_req[i].dest != '0) begin
                    p = free_q.pop_front();
                    old_q.push_back(model_map[rename_req[i].dest]);
                    model_map[rename_req[i].dest] = p;
                    model_prf[p].valid = 1'b0;
                    unwritten_q.push_back(p);
                    last_alloc = p;
                end
                if (commit_prn[i] != '0) begin
                    free_q.push_back(commit_prn[i]);
                end
            end

            // stalled group is held unchanged
            req = rename_req;
            need_n = 0;
            for (int i = 0; i < width; i++) begin
                if (!exp_stall) begin
                    req[i].valid = c >= idle_cycles && (next_bit() || next_bit());
                    req[i].dest = arch_reg_t'(rand_bits(5));
                    req[i].src1 = arch_reg_t'(rand_bits(5));
                    req[i].src2 = arch_reg_t'(rand_bits(5));
                end
                if (req[i].valid && req[i].dest != '0) begin
                    need_n++;
                end
            end
            stall_n = free_q.size() < need_n;

            // walk in program order so later slots see earlier dests
            walk_map = model_map;
            idx = 0;
            for (int i = 0; i < width; i++) begin
                resp[i].src1_prn = walk_map[req[i].src1];
                resp[i].src2_prn = walk_map[req[i].src2];
                resp[i].old_prn = walk_map[req[i].dest];
                resp[i].dest_prn = '0;
                if (!stall_n && req[i].valid && req[i].dest != '0) begin
                    resp[i].dest_prn = free_q[idx];
                    walk_map[req[i].dest] = free_q[idx];
                    idx++;
                end
            end

            for (int j = 0; j < width; j++) begin
                wr[j] = '0;
                cm[j] = '0;
                if (unwritten_q.size() > 0 && next_bit()) begin
                    idx = int'(rand_bits(6)) % unwritten_q.size();
                    wr[j] = '{data: rand_bits(32), prn: unwritten_q[idx]};
                    unwritten_q.delete(idx);
                end
                if ((c < hold_start || c >= hold_end) && old_q.size() > 0
                        && (next_bit() || next_bit())) begin
                    cm[j] = old_q.pop_front();
                    for (int q = unwritten_q.size() - 1; q >= 0; q--) begin
                        if (unwritten_q[q] == cm[j]) begin
                            unwritten_q.delete(q);
                        end
                    end
                end
            end

            for (int q = 0; q < 2 * width; q++) begin
                if (c < idle_cycles) begin
                    rd[q] = prn_t'(4 * c + q);
                end else if (q == 0 && wr[0].prn != '0) begin
                    rd[q] = wr[0].prn;
                end else if (q == 1) begin
                    rd[q] = last_alloc;
                end else begin
                    rd[q] = prn_t'(rand_bits(6));
                end
                rdv[q] = model_prf[rd[q]];
                for (int j = 0; j < width; j++) begin
                    if (wr[j].prn != '0 && wr[j].prn == rd[q]) begin
                        rdv[q] = '{valid: 1'b1, data: wr[j].data};
                    end
                end
            end

            rename_req <= req;
            write_data <= wr;
            commit_prn <= cm;
            read_prn <= rd;
            exp_resp <= resp;
            exp_stall <= stall_n;
            exp_read <= rdv;
        end
        // last group is checked at this edge
        @(posedge clock);
        @(negedge clock);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/rename_pkg.sv
hdl/regfile_pkg.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/prf.sv
hdl/rename_core.sv
tb/tb_rename_core.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_rename_core -f verilog.f
	./obj_dir/Vtb_rename_core > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
